/* rtl/reg_pkg.sv */
package reg_pkg;

  // Architectural register file seen by software
  localparam int NUM_ARCH_REGS = 32;

  // Physical register file behind the rename map
  localparam int NUM_PHYS_REGS = 64;

  localparam int ARCH_REG_W = $clog2(NUM_ARCH_REGS); // 5 bits
  localparam int PHYS_REG_W = $clog2(NUM_PHYS_REGS); // 6 bits

  // Architectural register number as it appears in the instruction
  typedef logic [ARCH_REG_W-1:0] arch_reg_t;

  // Physical register number, also the free queue entry type
  typedef logic [PHYS_REG_W-1:0] phys_reg_t;

endpackage

/* rtl/uop_pkg.sv */
package uop_pkg;

  // Instructions per rename group, also commit frees per cycle
  localparam int RENAME_WIDTH = 2;

  localparam int SLOT_COUNT_W = $clog2(RENAME_WIDTH + 1);          // Holds 0..RENAME_WIDTH
  localparam int FREE_COUNT_W = $clog2(reg_pkg::NUM_PHYS_REGS + 1); // Holds 0..NUM_PHYS_REGS

  // Number of slots in a group, used for pops and pushes
  typedef logic [SLOT_COUNT_W-1:0] slot_count_t;

  // Number of free physical registers in the queue
  typedef logic [FREE_COUNT_W-1:0] free_count_t;

endpackage

/* rtl/free_list.sv */
module free_list (
  input  logic                                           clk,
  input  logic                                           rst,
  input  uop_pkg::slot_count_t                           pop_count,  // Entries taken at head
  input  logic [uop_pkg::RENAME_WIDTH-1:0]               free_valid, // Commit frees per slot
  input  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] free_phys,
  output reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] head_phys,  // Oldest free entries
  output uop_pkg::free_count_t                           free_count
);

  // Circular queue, one slot per physical register so it can never overflow
  reg_pkg::phys_reg_t queue [reg_pkg::NUM_PHYS_REGS];

  reg_pkg::phys_reg_t   head;  // Oldest free entry
  reg_pkg::phys_reg_t   tail;  // Next slot to write
  uop_pkg::free_count_t count; // Explicit count, head == tail is both full and empty

  uop_pkg::slot_count_t push_count;                       // Valid frees this cycle
  reg_pkg::phys_reg_t   push_ptr [uop_pkg::RENAME_WIDTH]; // Tail slot per freeing slot

  // Frees are packed at the tail in slot order, slot 0 first
  always_comb begin
    push_count = '0;
    for (int i = 0; i < uop_pkg::RENAME_WIDTH; i++) begin
      push_ptr[i] = tail + reg_pkg::phys_reg_t'(push_count);
      if (free_valid[i]) begin
        push_count = push_count + uop_pkg::slot_count_t'(1);
      end
    end
  end

  // Head entries in age order, pointer wraps with the 6 bit add
  always_comb begin
    for (int i = 0; i < uop_pkg::RENAME_WIDTH; i++) begin
      head_phys[i] = queue[head + reg_pkg::phys_reg_t'(i)];
    end
  end

  assign free_count = count;

  // Queue contents
  always_ff @(posedge clk) begin
    if (rst) begin
      // Entries 0..31 hold registers 32..63; the upper half is stale until written
      for (int i = 0; i < reg_pkg::NUM_PHYS_REGS; i++) begin
        queue[i] <= reg_pkg::phys_reg_t'(i + reg_pkg::NUM_ARCH_REGS);
      end
    end else begin
      for (int i = 0; i < uop_pkg::RENAME_WIDTH; i++) begin
        if (free_valid[i]) begin
          queue[push_ptr[i]] <= free_phys[i]; // Freed register joins at tail
        end
      end
    end
  end

  // Pointers and count
  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= reg_pkg::phys_reg_t'(reg_pkg::NUM_PHYS_REGS - reg_pkg::NUM_ARCH_REGS);
      count <= uop_pkg::free_count_t'(reg_pkg::NUM_PHYS_REGS - reg_pkg::NUM_ARCH_REGS);
    end else begin
      head  <= head + reg_pkg::phys_reg_t'(pop_count);  // Pops never exceed count
      tail  <= tail + reg_pkg::phys_reg_t'(push_count);
      count <= count + uop_pkg::free_count_t'(push_count)
                     - uop_pkg::free_count_t'(pop_count);
    end
  end

endmodule

/* rtl/map_table.sv */
module map_table (
  input  logic                                           clk,
  input  logic                                           rst,
  input  reg_pkg::arch_reg_t [uop_pkg::RENAME_WIDTH-1:0] src1_arch,
  input  reg_pkg::arch_reg_t [uop_pkg::RENAME_WIDTH-1:0] src2_arch,
  input  reg_pkg::arch_reg_t [uop_pkg::RENAME_WIDTH-1:0] dest_arch,
  output reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] src1_phys,
  output reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] src2_phys,
  output reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] old_phys,  // Mapping being replaced
  input  logic [uop_pkg::RENAME_WIDTH-1:0]               wr_en,
  input  reg_pkg::arch_reg_t [uop_pkg::RENAME_WIDTH-1:0] wr_arch,
  input  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] wr_phys
);

  // Speculative map, one physical register per architectural register
  reg_pkg::phys_reg_t map [reg_pkg::NUM_ARCH_REGS];

  // Six read ports; all see the map before the current group
  always_comb begin
    for (int i = 0; i < uop_pkg::RENAME_WIDTH; i++) begin
      src1_phys[i] = map[src1_arch[i]];
      src2_phys[i] = map[src2_arch[i]];
      old_phys[i]  = map[dest_arch[i]];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_pkg::NUM_ARCH_REGS; i++) begin
        map[i] <= reg_pkg::phys_reg_t'(i); // Identity map out of reset
      end
    end else begin
      // Later slot is younger, last write in the loop wins
      for (int i = 0; i < uop_pkg::RENAME_WIDTH; i++) begin
        if (wr_en[i]) begin
          map[wr_arch[i]] <= wr_phys[i];
        end
      end
    end
  end

endmodule

/* rtl/rename_stage.sv */
module rename_stage (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           in_valid,
  output logic                                           in_ready,
  input  logic [uop_pkg::RENAME_WIDTH-1:0]               in_dest_valid,
  input  reg_pkg::arch_reg_t [uop_pkg::RENAME_WIDTH-1:0] in_src1_arch,
  input  reg_pkg::arch_reg_t [uop_pkg::RENAME_WIDTH-1:0] in_src2_arch,
  input  reg_pkg::arch_reg_t [uop_pkg::RENAME_WIDTH-1:0] in_dest_arch,
  input  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] head_phys,     // From free list
  input  uop_pkg::free_count_t                           free_count,
  output uop_pkg::slot_count_t                           pop_count,
  input  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] map_src1_phys, // From map table
  input  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] map_src2_phys,
  input  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] map_old_phys,
  output logic [uop_pkg::RENAME_WIDTH-1:0]               wr_en,         // To map table
  output reg_pkg::arch_reg_t [uop_pkg::RENAME_WIDTH-1:0] wr_arch,
  output reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] wr_phys,
  output logic                                           out_valid,
  output logic [uop_pkg::RENAME_WIDTH-1:0]               out_dest_valid,
  output reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] out_src1_phys,
  output reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] out_src2_phys,
  output reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] out_dest_phys,
  output reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] out_old_dest_phys
);

  uop_pkg::slot_count_t                           need_count; // Destinations in group
  uop_pkg::slot_count_t                           seen;       // Destinations in older slots
  logic                                           accept;
  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] dest_phys;  // New register per slot
  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] src1_fix;   // After group bypass
  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] src2_fix;
  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] old_fix;

  // Compacted allocation, each destination takes the next head entry
  always_comb begin
    seen = '0;
    for (int i = 0; i < uop_pkg::RENAME_WIDTH; i++) begin
      dest_phys[i] = head_phys[0];
      for (int j = 0; j < uop_pkg::RENAME_WIDTH; j++) begin
        if (seen == uop_pkg::slot_count_t'(j)) begin
          dest_phys[i] = head_phys[j];
        end
      end
      if (in_dest_valid[i]) begin
        seen = seen + uop_pkg::slot_count_t'(1);
      end
    end
    need_count = seen;
  end

  // Stall only on too few free registers
  assign in_ready  = free_count >= uop_pkg::free_count_t'(need_count);
  assign accept    = in_valid && in_ready;
  assign pop_count = accept ? need_count : '0;

  assign wr_en   = accept ? in_dest_valid : '0;
  assign wr_arch = in_dest_arch;
  assign wr_phys = dest_phys;

  // Intra-group RAW and WAW fixes
  always_comb begin
    for (int i = 0; i < uop_pkg::RENAME_WIDTH; i++) begin
      src1_fix[i] = map_src1_phys[i];
      src2_fix[i] = map_src2_phys[i];
      old_fix[i]  = map_old_phys[i];
      // Youngest older producer wins, so scan oldest first
      for (int j = 0; j < i; j++) begin
        if (in_dest_valid[j] && in_dest_arch[j] == in_src1_arch[i]) begin
          src1_fix[i] = dest_phys[j];
        end
        if (in_dest_valid[j] && in_dest_arch[j] == in_src2_arch[i]) begin
          src2_fix[i] = dest_phys[j];
        end
        if (in_dest_valid[j] && in_dest_arch[j] == in_dest_arch[i]) begin
          old_fix[i] = dest_phys[j]; // Freed at commit instead of the map entry
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= accept; // One cycle pulse per accepted group
    end
  end

  // Output payload, qualified by out_valid
  always_ff @(posedge clk) begin
    if (accept) begin
      out_dest_valid    <= in_dest_valid;
      out_src1_phys     <= src1_fix;
      out_src2_phys     <= src2_fix;
      out_dest_phys     <= dest_phys;
      out_old_dest_phys <= old_fix;
    end
  end

endmodule

/* rtl/rename_unit.sv */
module rename_unit (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           in_valid,
  output logic                                           in_ready,
  input  logic [uop_pkg::RENAME_WIDTH-1:0]               in_dest_valid,
  input  reg_pkg::arch_reg_t [uop_pkg::RENAME_WIDTH-1:0] in_src1_arch,
  input  reg_pkg::arch_reg_t [uop_pkg::RENAME_WIDTH-1:0] in_src2_arch,
  input  reg_pkg::arch_reg_t [uop_pkg::RENAME_WIDTH-1:0] in_dest_arch,
  input  logic [uop_pkg::RENAME_WIDTH-1:0]               free_valid,  // Commit side
  input  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] free_phys,
  output logic                                           out_valid,
  output logic [uop_pkg::RENAME_WIDTH-1:0]               out_dest_valid,
  output reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] out_src1_phys,
  output reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] out_src2_phys,
  output reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] out_dest_phys,
  output reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] out_old_dest_phys
);

  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] head_phys;
  uop_pkg::free_count_t                           free_count;
  uop_pkg::slot_count_t                           pop_count;
  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] map_src1_phys;
  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] map_src2_phys;
  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] map_old_phys;
  logic [uop_pkg::RENAME_WIDTH-1:0]               wr_en;
  reg_pkg::arch_reg_t [uop_pkg::RENAME_WIDTH-1:0] wr_arch;
  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] wr_phys;

  free_list u_free_list (
    .clk        (clk),
    .rst        (rst),
    .pop_count  (pop_count),
    .free_valid (free_valid),
    .free_phys  (free_phys),
    .head_phys  (head_phys),
    .free_count (free_count)
  );

  // Map reads use the raw instruction fields
  map_table u_map_table (
    .clk       (clk),
    .rst       (rst),
    .src1_arch (in_src1_arch),
    .src2_arch (in_src2_arch),
    .dest_arch (in_dest_arch),
    .src1_phys (map_src1_phys),
    .src2_phys (map_src2_phys),
    .old_phys  (map_old_phys),
    .wr_en     (wr_en),
    .wr_arch   (wr_arch),
    .wr_phys   (wr_phys)
  );

  rename_stage u_rename_stage (
    .clk               (clk),
    .rst               (rst),
    .in_valid          (in_valid),
    .in_ready          (in_ready),
    .in_dest_valid     (in_dest_valid),
    .in_src1_arch      (in_src1_arch),
    .in_src2_arch      (in_src2_arch),
    .in_dest_arch      (in_dest_arch),
    .head_phys         (head_phys),
    .free_count        (free_count),
    .pop_count         (pop_count),
    .map_src1_phys     (map_src1_phys),
    .map_src2_phys     (map_src2_phys),
    .map_old_phys      (map_old_phys),
    .wr_en             (wr_en),
    .wr_arch           (wr_arch),
    .wr_phys           (wr_phys),
    .out_valid         (out_valid),
    .out_dest_valid    (out_dest_valid),
    .out_src1_phys     (out_src1_phys),
    .out_src2_phys     (out_src2_phys),
    .out_dest_phys     (out_dest_phys),
    .out_old_dest_phys (out_old_dest_phys)
  );

endmodule

/* testbench/rename_unit_properties.sv */
module rename_unit_properties (
  input logic                             clk,
  input logic                             rst,
  input logic                             in_valid,
  input logic                             in_ready,
  input logic                             out_valid,
  input logic [uop_pkg::RENAME_WIDTH-1:0] out_dest_valid,
  input uop_pkg::free_count_t             free_count
);

  // Fixed one cycle latency in both directions
  accept_gives_out: assert property (@(posedge clk) disable iff (rst)
    (in_valid && in_ready) |=> out_valid)
    else $error("out_valid missing one cycle after acceptance");
  out_needs_accept: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> $past(in_valid && in_ready))
    else $error("out_valid without an accepted group in the previous cycle");

  // Map always holds 32 registers, so at most 32 are free
  count_bound: assert property (@(posedge clk) disable iff (rst)
    free_count <= uop_pkg::free_count_t'(reg_pkg::NUM_PHYS_REGS - reg_pkg::NUM_ARCH_REGS))
    else $error("free_count above the number of renamable registers");

  // Renamed group had a free register for each destination when it was accepted
  ready_needs_regs: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> $past(free_count) >= uop_pkg::free_count_t'($countones(out_dest_valid)))
    else $error("Group accepted with too few free registers");

  reset_clears_out: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high after a reset cycle");

endmodule

/* testbench/rename_unit_tb.sv */
module rename_unit_tb;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_TESTS  = 6;

  typedef reg_pkg::arch_reg_t [uop_pkg::RENAME_WIDTH-1:0] arch_pair_t;

  logic                                           clk;
  logic                                           rst;
  logic                                           in_valid;
  logic                                           in_ready;
  logic [uop_pkg::RENAME_WIDTH-1:0]               in_dest_valid;
  arch_pair_t                                     in_src1_arch;
  arch_pair_t                                     in_src2_arch;
  arch_pair_t                                     in_dest_arch;
  logic [uop_pkg::RENAME_WIDTH-1:0]               free_valid;
  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] free_phys;
  logic                                           out_valid;
  logic [uop_pkg::RENAME_WIDTH-1:0]               out_dest_valid;
  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] out_src1_phys;
  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] out_src2_phys;
  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] out_dest_phys;
  reg_pkg::phys_reg_t [uop_pkg::RENAME_WIDTH-1:0] out_old_dest_phys;

  reg_pkg::phys_reg_t model_map [reg_pkg::NUM_ARCH_REGS]; // Reference rename map
  reg_pkg::phys_reg_t free_q [$];                         // Reference free queue, head first
  reg_pkg::phys_reg_t retire_q [$];                       // Old mappings waiting for commit
  int                 error_count;
  int                 cycle_count;

  rename_unit u_rename_unit (.*);

  bind rename_unit rename_unit_properties u_rename_unit_properties (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .out_valid      (out_valid),
    .out_dest_valid (out_dest_valid),
    .free_count     (free_count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 1;

  task automatic check_value(input string test, input string field, input int expected,
                             input int actual);
    assert (expected == actual) else begin
      error_count++;
      $display("[ERROR] %s %s: expected %0d, actual %0d", test, field, expected, actual);
      $display("Simulation failed");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  function automatic arch_pair_t rand_regs();
    arch_pair_t r;
    for (int i = 0; i < uop_pkg::RENAME_WIDTH; i++) begin
      r[i] = reg_pkg::arch_reg_t'($urandom_range(reg_pkg::NUM_ARCH_REGS - 1, 0));
    end
    return r;
  endfunction

  // Group stays on the inputs until finish_group sees it accepted
  task automatic drive_group(input logic [1:0] dv, input arch_pair_t s1, input arch_pair_t s2,
                             input arch_pair_t d);
    @(posedge clk);
    in_valid      <= 1'b1;
    in_dest_valid <= dv;
    in_src1_arch  <= s1;
    in_src2_arch  <= s2;
    in_dest_arch  <= d;
  endtask

  task automatic finish_group(input string test);
    reg_pkg::phys_reg_t               exp_src1 [uop_pkg::RENAME_WIDTH];
    reg_pkg::phys_reg_t               exp_src2 [uop_pkg::RENAME_WIDTH];
    reg_pkg::phys_reg_t               exp_dest [uop_pkg::RENAME_WIDTH];
    reg_pkg::phys_reg_t               exp_old [uop_pkg::RENAME_WIDTH];
    logic [uop_pkg::RENAME_WIDTH-1:0] dv;
    int                               taken;
    @(negedge clk);
    while (!in_ready) @(negedge clk); // Stalled on free registers
    dv    = in_dest_valid;
    taken = 0;
    for (int i = 0; i < uop_pkg::RENAME_WIDTH; i++) begin
      exp_src1[i] = model_map[in_src1_arch[i]];
      exp_src2[i] = model_map[in_src2_arch[i]];
      exp_old[i]  = model_map[in_dest_arch[i]];
      exp_dest[i] = '0;
      if (dv[i]) begin
        exp_dest[i] = free_q[taken]; // Compacted allocation from the head
        taken++;
      end
    end
    // Younger slot reads the older slot's new register
    if (dv[0]) begin
      if (in_src1_arch[1] == in_dest_arch[0]) exp_src1[1] = exp_dest[0];
      if (in_src2_arch[1] == in_dest_arch[0]) exp_src2[1] = exp_dest[0];
      if (in_dest_arch[1] == in_dest_arch[0]) exp_old[1] = exp_dest[0];
    end
    for (int i = 0; i < uop_pkg::RENAME_WIDTH; i++) begin
      if (dv[i]) begin
        model_map[in_dest_arch[i]] = exp_dest[i]; // Slot 1 goes last and wins
        retire_q.push_back(exp_old[i]);
        void'(free_q.pop_front());
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
    @(negedge clk);
    check_value(test, "out_valid", 1, int'(out_valid));
    check_value(test, "out_dest_valid", int'(dv), int'(out_dest_valid));
    for (int i = 0; i < uop_pkg::RENAME_WIDTH; i++) begin
      check_value(test, $sformatf("src1[%0d]", i), int'(exp_src1[i]), int'(out_src1_phys[i]));
      check_value(test, $sformatf("src2[%0d]", i), int'(exp_src2[i]), int'(out_src2_phys[i]));
      if (dv[i]) begin
        check_value(test, $sformatf("dest[%0d]", i), int'(exp_dest[i]), int'(out_dest_phys[i]));
        check_value(test, $sformatf("old[%0d]", i), int'(exp_old[i]),
                    int'(out_old_dest_phys[i]));
      end
    end
  endtask

  // Commit returns the oldest retired mappings in slot order
  task automatic free_regs(input logic [1:0] fv);
    reg_pkg::phys_reg_t r;
    @(posedge clk);
    free_valid <= fv;
    for (int i = 0; i < uop_pkg::RENAME_WIDTH; i++) begin
      if (fv[i]) begin
        r = retire_q.pop_front();
        free_phys[i] <= r;
        free_q.push_back(r);
      end
    end
    @(posedge clk);
    free_valid <= '0;
  endtask

  task automatic reset_identity();
    drive_group(2'b00, {5'd7, 5'd1}, {5'd31, 5'd0}, {5'd0, 5'd0});
    finish_group("reset_identity");
    drive_group(2'b00, rand_regs(), rand_regs(), rand_regs());
    finish_group("reset_identity");
  endtask

  task automatic allocation_order();
    repeat (3) begin
      drive_group(2'b11, rand_regs(), rand_regs(), rand_regs());
      finish_group("allocation_order");
    end
    drive_group(2'b10, rand_regs(), rand_regs(), rand_regs()); // Slot 1 takes head entry 0
    finish_group("allocation_order");
    drive_group(2'b01, rand_regs(), rand_regs(), rand_regs());
    finish_group("allocation_order");
  endtask

  task automatic group_bypass();
    drive_group(2'b11, {5'd9, 5'd2}, {5'd9, 5'd3}, {5'd9, 5'd9}); // All of slot 1 hits r9
    finish_group("group_bypass");
    drive_group(2'b00, {5'd9, 5'd9}, {5'd4, 5'd9}, {5'd0, 5'd0}); // Sees slot 1's write
    finish_group("group_bypass");
  endtask

  task automatic free_list_exhaustion();
    while (free_q.size() > 0) begin
      drive_group((free_q.size() >= 2) ? 2'b11 : 2'b01, rand_regs(), rand_regs(), rand_regs());
      finish_group("free_list_exhaustion");
    end
    drive_group(2'b11, rand_regs(), rand_regs(), rand_regs());
    repeat (5) begin
      @(negedge clk);
      check_value("free_list_exhaustion", "in_ready", 0, int'(in_ready));
    end
    free_regs(2'b11);
    finish_group("free_list_exhaustion");
  endtask

  task automatic register_reuse();
    free_regs(2'b10);
    free_regs(2'b01);
    free_regs(2'b11);
    repeat (2) begin
      drive_group(2'b11, rand_regs(), rand_regs(), rand_regs());
      finish_group("register_reuse");
    end
  endtask

  task automatic random_traffic();
    int         start;
    logic [1:0] dv;
    start = cycle_count;
    while (cycle_count - start < 200) begin
      dv = 2'($urandom_range(3, 0));
      // Map plus both queues always hold all 64 registers
      if (retire_q.size() >= 2 && ($urandom_range(1, 0) == 1 || $countones(dv) > free_q.size()))
        free_regs(2'($urandom_range(3, 1)));
      else begin
        drive_group(dv, rand_regs(), rand_regs(), rand_regs());
        finish_group("random_traffic");
      end
    end
  endtask

  initial begin
    void'($urandom(38));
    clk           = 1'b0;
    rst           = 1'b1;
    in_valid      = 1'b0;
    in_dest_valid = '0;
    in_src1_arch  = '0;
    in_src2_arch  = '0;
    in_dest_arch  = '0;
    free_valid    = '0;
    free_phys     = '0;
    error_count   = 0;
    cycle_count   = 0;
    for (int i = 0; i < reg_pkg::NUM_ARCH_REGS; i++) model_map[i] = reg_pkg::phys_reg_t'(i);
    for (int i = reg_pkg::NUM_ARCH_REGS; i < reg_pkg::NUM_PHYS_REGS; i++) begin
      free_q.push_back(reg_pkg::phys_reg_t'(i));
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    reset_identity();
    allocation_order();
    group_bypass();
    free_list_exhaustion();
    register_reuse();
    random_traffic();
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog allows 200 cycles per test
  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * 200);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* sim.f */
rtl/reg_pkg.sv
rtl/uop_pkg.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/rename_stage.sv
rtl/rename_unit.sv
testbench/rename_unit_properties.sv
testbench/rename_unit_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= rename_unit_tb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
